// ==== test/dmem_cases.txt ====
# columns, all hex: op(0 idle 1 store 2 load) funct3 addr data rd trigger expected
# data is the store data, expected is wb_data of a load
# word store then little-endian byte loads
1 2 00000040 a1b2c3d4 00 0 00000000
2 2 00000040 00000000 01 0 a1b2c3d4
2 4 00000040 00000000 02 0 000000d4
2 4 00000041 00000000 03 0 000000c3
2 4 00000042 00000000 04 0 000000b2
2 4 00000043 00000000 05 0 000000a1
0 0 00000000 00000000 00 0 00000000
# half and byte stores merge into a word
1 2 00000050 11223344 00 0 00000000
1 1 00000052 ffffbeef 00 0 00000000
1 0 00000051 12345699 00 0 00000000
2 2 00000050 00000000 06 0 beef9944
2 5 00000052 00000000 07 0 0000beef
# sign and zero extension
1 2 00000060 12348080 00 0 00000000
2 0 00000060 00000000 08 0 ffffff80
2 4 00000060 00000000 09 0 00000080
2 1 00000060 00000000 0a 0 ffff8080
2 5 00000060 00000000 0b 0 00008080
2 1 00000062 00000000 0c 0 00001234
2 0 00000063 00000000 0d 0 00000012
2 0 00000040 00000000 0e 0 ffffffd4
# trigger read back through the synchronizer
0 0 00000000 00000000 00 1 00000000
0 0 00000000 00000000 00 1 00000000
0 0 00000000 00000000 00 1 00000000
2 2 00000100 00000000 10 1 00000001
0 0 00000000 00000000 00 0 00000000
0 0 00000000 00000000 00 0 00000000
0 0 00000000 00000000 00 0 00000000
2 2 00000100 00000000 11 0 00000000
# illegal funct3 for store and load
1 2 00000070 cafef00d 00 0 00000000
1 4 00000070 00000055 00 0 00000000
2 2 00000070 00000000 12 0 cafef00d
2 3 00000070 00000000 1f 0 00000000
2 7 00000070 00000000 1e 0 00000000

// ==== project.f ====
hw/dmem_pkg.sv
hw/mem_request_decoder.sv
hw/data_memory.sv
hw/load_writeback.sv
hw/dmem_subsystem.sv
test/dmem_assert.sv
test/tb_dmem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dmem
FILELIST  ?= project.f
CASES     ?= test/dmem_cases.txt
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(CASES)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F '*** FAILED ***' $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q -F '*** PASSED ***' $(LOG) || { echo "simulation ended without passing"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_dmem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dmem
    import dmem_pkg::*;
();

    localparam int DATA_WIDTH = 32;
    localparam int MAX_CASES  = 64;
    localparam int RAND_COUNT = 8;   // word store/load pairs
    localparam logic [DATA_WIDTH-1:0] RAND_BASE = 32'h0000_1000;

    localparam logic [1:0] OP_IDLE  = 2'd0;
    localparam logic [1:0] OP_STORE = 2'd1;
    localparam logic [1:0] OP_LOAD  = 2'd2;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  mem_read;
    logic                  mem_write;
    mem_funct3_e           funct3;
    logic [DATA_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] store_data;
    logic [4:0]            rd_in;
    logic                  trigger_in;
    logic                  wb_valid;
    logic [4:0]            wb_rd;
    logic [DATA_WIDTH-1:0] wb_data;

    // request table from the cases file
    logic [1:0]            case_op   [MAX_CASES];
    logic [2:0]            case_f3   [MAX_CASES];
    logic [DATA_WIDTH-1:0] case_addr [MAX_CASES];
    logic [DATA_WIDTH-1:0] case_data [MAX_CASES];
    logic [4:0]            case_rd   [MAX_CASES];
    logic                  case_trig [MAX_CASES];
    logic [DATA_WIDTH-1:0] case_exp  [MAX_CASES];
    int                    num_cases;

    int cycle_count = 0;
    int cycle_limit = 0;  // 0 until the table is read
    int seed;
    int req_index;
    int prev_index;

    logic [1:0]            prev_op;    // request issued last cycle
    logic [4:0]            prev_rd;
    logic [DATA_WIDTH-1:0] prev_exp;
    logic [4:0]            held_rd;    // last writeback values
    logic [DATA_WIDTH-1:0] held_data;

    dmem_subsystem u_dmem_subsystem (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .funct3     (funct3),
        .addr       (addr),
        .store_data (store_data),
        .rd_in      (rd_in),
        .trigger_in (trigger_in),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    bind dmem_subsystem dmem_assert u_assert (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .load_req  (load_req),
        .wb_valid  (wb_valid)
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            abort_run($sformatf("timeout, run not finished after %0d cycles", cycle_count));
        end
    end

    task automatic check_data(input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            abort_run($sformatf("ERROR wb_data: got 0x%08h expected 0x%08h at request %0d",
                                got, exp, prev_index));
        end
    endtask

    task automatic check_rd(input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp)
        begin
            abort_run($sformatf("ERROR wb_rd: got 0x%02h expected 0x%02h at request %0d",
                                got, exp, prev_index));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp)
        begin
            abort_run($sformatf("ERROR wb_valid: got 0x%0h expected 0x%0h at request %0d",
                                got, exp, prev_index));
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        int          op_v;
        int          f3_v;
        int          rd_v;
        int          trig_v;
        logic [31:0] addr_v;
        logic [31:0] data_v;
        logic [31:0] exp_v;
        string       line;

        fd = $fopen("test/dmem_cases.txt", "r");
        if (fd == 0)
        begin
            abort_run("could not open test/dmem_cases.txt");
        end
        num_cases = 0;
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#")
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            op_v, f3_v, addr_v, data_v, rd_v, trig_v, exp_v);
                if (n == 7)
                begin
                    if (op_v > 2 || num_cases >= MAX_CASES)
                    begin
                        abort_run($sformatf("bad op or too many lines near case %0d", num_cases));
                    end
                    case_op[num_cases]   = op_v[1:0];
                    case_f3[num_cases]   = f3_v[2:0];
                    case_addr[num_cases] = addr_v;
                    case_data[num_cases] = data_v;
                    case_rd[num_cases]   = rd_v[4:0];
                    case_trig[num_cases] = trig_v[0];
                    case_exp[num_cases]  = exp_v;
                    num_cases++;
                end
                else if (n > 0)
                begin
                    abort_run($sformatf("malformed line after case %0d", num_cases));
                end
            end
        end
        $fclose(fd);
    endtask

    // results of the request issued one cycle earlier
    task automatic verify_writeback();
        if (prev_op == OP_LOAD)
        begin
            check_valid(wb_valid, 1'b1);
            check_rd(wb_rd, prev_rd);
            check_data(wb_data, prev_exp);
            held_rd   = prev_rd;
            held_data = prev_exp;
        end
        else
        begin
            check_valid(wb_valid, 1'b0);
            check_rd(wb_rd, held_rd);        // held since the last load
            check_data(wb_data, held_data);
        end
    endtask

    task automatic issue_request(input logic [1:0]            op,
                                 input logic [2:0]            f3,
                                 input logic [DATA_WIDTH-1:0] a,
                                 input logic [DATA_WIDTH-1:0] d,
                                 input logic [4:0]            rd,
                                 input logic                  trig,
                                 input logic [DATA_WIDTH-1:0] exp);
        @(posedge clk);
        #0.5;
        verify_writeback();
        mem_read   = (op == OP_LOAD);
        mem_write  = (op == OP_STORE);
        funct3     = mem_funct3_e'(f3);
        addr       = a;
        store_data = d;
        rd_in      = rd;
        trigger_in = trig;
        prev_op    = op;
        prev_rd    = rd;
        prev_exp   = exp;
        prev_index = req_index;
        req_index++;
    endtask

    initial
    begin
        logic [DATA_WIDTH-1:0] rand_word;
        logic [DATA_WIDTH-1:0] rand_addr;

        arst_n     = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        funct3     = F3_W;
        addr       = '0;
        store_data = '0;
        rd_in      = '0;
        trigger_in = 1'b0;
        prev_op    = OP_IDLE;
        prev_rd    = '0;
        prev_exp   = '0;
        held_rd    = '0;
        held_data  = '0;
        req_index  = 0;
        prev_index = 0;
        seed       = 68216;

        load_cases();
        cycle_limit = (num_cases + RAND_COUNT) * 2 + 20;

        @(posedge clk);
        #0.5;
        check_valid(wb_valid, 1'b0);  // still in reset
        @(posedge clk);
        #0.5;
        arst_n = 1'b1;

        for (int i = 0; i < num_cases; i++)
        begin
            issue_request(case_op[i], case_f3[i], case_addr[i], case_data[i],
                          case_rd[i], case_trig[i], case_exp[i]);
        end

        // random words, each read back right after its store
        for (int k = 0; k < RAND_COUNT; k++)
        begin
            rand_word = $random(seed);
            rand_addr = RAND_BASE + 32'(4 * k);
            issue_request(OP_STORE, F3_W, rand_addr, rand_word, 5'd0, 1'b0, '0);
            issue_request(OP_LOAD, F3_W, rand_addr, '0, 5'(k + 1), 1'b0, rand_word);
        end

        issue_request(OP_IDLE, F3_W, '0, '0, 5'd0, 1'b0, '0);
        @(posedge clk);
        #0.5;
        verify_writeback();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/dmem_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module dmem_assert (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic mem_read,
    input wire logic mem_write,
    input wire logic load_req,
    input wire logic wb_valid
);

    // a request is either a load or a store
    a_one_strobe: assert property (
        @(posedge clk) disable iff (!arst_n) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write high in the same cycle");

    a_valid_after_load: assert property (
        @(posedge clk) disable iff (!arst_n) load_req |=> wb_valid
    ) else $error("wb_valid missing one cycle after load_req");

    // no extra pulses
    a_valid_only_after_load: assert property (
        @(posedge clk) disable iff (!arst_n) !load_req |=> !wb_valid
    ) else $error("wb_valid high without a load in the previous cycle");

    a_valid_low_in_reset: assert property (
        @(posedge clk) !arst_n |-> !wb_valid
    ) else $error("wb_valid high during reset");

endmodule

`default_nettype wire

// ==== hw/dmem_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module dmem_subsystem
    import dmem_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_BITS  = 17   // 128 KiB
)(
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  mem_read,
    input  wire logic                  mem_write,
    input  mem_funct3_e                funct3,
    input  wire logic [DATA_WIDTH-1:0] addr,
    input  wire logic [DATA_WIDTH-1:0] store_data,
    input  wire logic [4:0]            rd_in,
    input  wire logic                  trigger_in,
    output logic                       wb_valid,
    output logic      [4:0]            wb_rd,
    output logic      [DATA_WIDTH-1:0] wb_data
);

    mem_mode_e             mode;
    logic                  we;
    logic                  load_req;
    logic                  trigger_sync;
    logic [DATA_WIDTH-1:0] rd_data;   // combinational load result

    mem_request_decoder u_decoder (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .funct3       (funct3),
        .trigger_in   (trigger_in),
        .mode         (mode),
        .we           (we),
        .load_req     (load_req),
        .trigger_sync (trigger_sync)
    );

    data_memory #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_BITS  (ADDR_BITS)
    ) u_memory (
        .clk          (clk),
        .mode         (mode),
        .addr         (addr),
        .store_data   (store_data),
        .we           (we),
        .trigger_sync (trigger_sync),
        .rd_data      (rd_data)
    );

    load_writeback #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_writeback (
        .clk      (clk),
        .arst_n   (arst_n),
        .load_req (load_req),
        .rd_in    (rd_in),
        .rd_data  (rd_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

// ==== hw/load_writeback.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_writeback #(
    parameter int DATA_WIDTH = 32
)(
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  load_req,
    input  wire logic [4:0]            rd_in,
    input  wire logic [DATA_WIDTH-1:0] rd_data,
    output logic                       wb_valid,
    output logic      [4:0]            wb_rd,
    output logic      [DATA_WIDTH-1:0] wb_data
);

    // one pulse per load
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_valid <= 1'b0;
        end
        else
        begin
            wb_valid <= load_req;
        end
    end

    // result and destination held until the next load
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_rd   <= '0;
            wb_data <= '0;
        end
        else if (load_req)
        begin
            wb_rd   <= rd_in;
            wb_data <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/data_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_memory
    import dmem_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_BITS  = 17   // 9 or more so the trigger address fits
)(
    input  wire logic                  clk,
    input  mem_mode_e                  mode,
    input  wire logic [DATA_WIDTH-1:0] addr,
    input  wire logic [DATA_WIDTH-1:0] store_data,
    input  wire logic                  we,
    input  wire logic                  trigger_sync,
    output logic      [DATA_WIDTH-1:0] rd_data
);

    localparam int NBYTES  = DATA_WIDTH / 8;
    localparam int DEPTH   = 2 ** ADDR_BITS;
    localparam int HBYTES  = 2;

    logic [7:0]            ram [DEPTH];
    logic [ADDR_BITS-1:0]  idx;        // upper address bits ignored
    logic [DATA_WIDTH-1:0] word_data;  // little-endian gather from idx

    assign idx = addr[ADDR_BITS-1:0];

    // stores, byte at idx gets the least significant byte
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            case (mode)
                MODE_WORD:
                begin
                    for (int k = 0; k < NBYTES; k++)
                    begin
                        ram[idx + ADDR_BITS'(k)] <= store_data[8*k +: 8];
                    end
                end
                MODE_HALF:
                begin
                    for (int k = 0; k < HBYTES; k++)
                    begin
                        ram[idx + ADDR_BITS'(k)] <= store_data[8*k +: 8];
                    end
                end
                MODE_BYTE:
                begin
                    ram[idx] <= store_data[7:0];
                end
                default:
                begin
                    // nothing written
                end
            endcase
        end
    end

    // address wraps inside the ram
    always_comb
    begin
        for (int k = 0; k < NBYTES; k++)
        begin
            word_data[8*k +: 8] = ram[idx + ADDR_BITS'(k)];
        end
    end

    always_comb
    begin
        if (addr == DATA_WIDTH'(TRIGGER_ADDR))
        begin
            rd_data = {{(DATA_WIDTH-1){1'b0}}, trigger_sync};  // full address match only
        end
        else
        begin
            case (mode)
                MODE_WORD:
                begin
                    rd_data = word_data;
                end
                MODE_HALF:
                begin
                    rd_data = {{(DATA_WIDTH-16){word_data[15]}}, word_data[15:0]};
                end
                MODE_BYTE:
                begin
                    rd_data = {{(DATA_WIDTH-8){word_data[7]}}, word_data[7:0]};
                end
                MODE_HALF_U:
                begin
                    rd_data = {{(DATA_WIDTH-16){1'b0}}, word_data[15:0]};
                end
                MODE_BYTE_U:
                begin
                    rd_data = {{(DATA_WIDTH-8){1'b0}}, word_data[7:0]};
                end
                default:
                begin
                    rd_data = '0;  // illegal funct3
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_request_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_request_decoder
    import dmem_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        mem_read,
    input  wire logic        mem_write,
    input  mem_funct3_e      funct3,
    input  wire logic        trigger_in,
    output mem_mode_e        mode,
    output logic             we,
    output logic             load_req,
    output logic             trigger_sync
);

    logic trigger_meta;  // first sync stage

    always_comb
    begin
        mode = MODE_NONE;
        if (mem_write)
        begin
            case (funct3)
                F3_B:    mode = MODE_BYTE;
                F3_H:    mode = MODE_HALF;
                F3_W:    mode = MODE_WORD;
                default: mode = MODE_NONE;  // unsigned stores do not exist
            endcase
        end
        else
        begin
            case (funct3)
                F3_B:    mode = MODE_BYTE;
                F3_H:    mode = MODE_HALF;
                F3_W:    mode = MODE_WORD;
                F3_BU:   mode = MODE_BYTE_U;
                F3_HU:   mode = MODE_HALF_U;
                default: mode = MODE_NONE;
            endcase
        end
    end

    assign we       = mem_write && (mode != MODE_NONE);
    assign load_req = mem_read;

    // two-flop synchronizer, trigger_in is asynchronous to clk
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            trigger_meta <= 1'b0;
            trigger_sync <= 1'b0;
        end
        else
        begin
            trigger_meta <= trigger_in;
            trigger_sync <= trigger_meta;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dmem_pkg.sv ====
`default_nettype none

package dmem_pkg;

    // rv32i load/store funct3 field
    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_BU = 3'b100,
        F3_HU = 3'b101
    } mem_funct3_e;

    // access mode seen by the data memory
    typedef enum logic [2:0] {
        MODE_NONE   = 3'd0,  // no access, loads read zero
        MODE_WORD   = 3'd1,
        MODE_HALF   = 3'd2,
        MODE_BYTE   = 3'd3,
        MODE_HALF_U = 3'd4,
        MODE_BYTE_U = 3'd5
    } mem_mode_e;

    // load from here returns the synchronized trigger in bit 0
    localparam logic [31:0] TRIGGER_ADDR = 32'h0000_0100;

endpackage

`default_nettype wire
